// ==== compile.f ====
+incdir+.
vic_timing_pkg.sv
vic_bus_pkg.sv
vic_phase_gen.sv
vic_raster.sv
vic_registers.sv
vic_bus_arbiter.sv
vicii.sv
tb_vicii.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_vicii
FILELIST  = compile.f
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_vicii.sv ====
`default_nettype none

`include "vic_params.svh"

module tb_vicii;

   timeunit 1ns;
   timeprecision 100ps;

   import vic_timing_pkg::*;
   import vic_bus_pkg::*;

   // two 6567R8 frames are 2*263*520*4 = 1094080 clocks
   // the limit adds some margin on top
   localparam int MAX_CYCLES = 1200000;

   logic         clk_dot4x;
   logic         rst;
   chip_e        chip_i;
   reg_addr_t    adi_i;
   reg_data_t    dbi_i;
   logic         ce_i;
   logic         rw_i;
   logic         clk_phi_o;
   raster_x_t    raster_x_o;
   raster_line_t raster_line_o;
   reg_data_t    dbo_o;
   logic         irq_o;
   logic         ba_o;
   logic         aec_o;
   logic         ls245_data_dir_o;
   logic         ls245_addr_dir_o;

   int        seed;
   int        error_count;
   int        cycle_count;
   reg_data_t d011_val;

   vicii u_dut (
      .clk_dot4x        (clk_dot4x),
      .rst              (rst),
      .chip_i           (chip_i),
      .adi_i            (adi_i),
      .dbi_i            (dbi_i),
      .ce_i             (ce_i),
      .rw_i             (rw_i),
      .clk_phi_o        (clk_phi_o),
      .raster_x_o       (raster_x_o),
      .raster_line_o    (raster_line_o),
      .dbo_o            (dbo_o),
      .irq_o            (irq_o),
      .ba_o             (ba_o),
      .aec_o            (aec_o),
      .ls245_data_dir_o (ls245_data_dir_o),
      .ls245_addr_dir_o (ls245_addr_dir_o)
   );

   // 4 ns dot4x clock
   initial clk_dot4x = 1'b0;
   always #2 clk_dot4x = ~clk_dot4x;

   // run limit
   always @(posedge clk_dot4x) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: run went past %0d clock cycles", MAX_CYCLES);
         $display("Finished with errors");
         $fatal(1);
      end
   end

   task automatic stop_with_error(input string what);
      error_count++;
      $display("error at %0t: %s", $time, what);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input reg_data_t actual,
                             input reg_data_t expected);
      if (actual !== expected) begin
         error_count++;
         $display("FAIL at %0t: %s = 0x%02h, expected 0x%02h", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1);
      end
   endtask

   task automatic check_line(input string name, input raster_line_t actual,
                             input raster_line_t expected);
      if (actual !== expected) begin
         error_count++;
         $display("FAIL at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1);
      end
   endtask

   task automatic check_x(input string name, input raster_x_t actual,
                          input raster_x_t expected);
      if (actual !== expected) begin
         error_count++;
         $display("FAIL at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1);
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         error_count++;
         $display("FAIL at %0t: %s = %b, expected %b", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1);
      end
   endtask

   task automatic check_count(input string name, input int actual, input int expected);
      if (actual != expected) begin
         error_count++;
         $display("FAIL at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1);
      end
   endtask

   task automatic apply_reset(input chip_e chip);
      @(posedge clk_dot4x);
      #1;
      rst    = 1'b1;
      chip_i = chip;
      ce_i   = 1'b1;
      rw_i   = 1'b1;
      repeat (8) @(posedge clk_dot4x);
      #1;
      rst = 1'b0;
   endtask

   // returns at the first negedge of the next phi high half
   task automatic skip_to_phi_high();
      @(negedge clk_dot4x);
      while (clk_phi_o) @(negedge clk_dot4x);
      while (!clk_phi_o) @(negedge clk_dot4x);
   endtask

   // optionally insists that irq_o stays quiet meanwhile
   task automatic wait_line(input raster_line_t line, input logic irq_quiet);
      @(negedge clk_dot4x);
      while (raster_line_o != line) begin
         if (irq_quiet)
            check_bit("irq_o", irq_o, 1'b0);
         @(negedge clk_dot4x);
      end
   endtask

   // one cpu cycle with ce_i low from a phi low half through the whole phi high half
   task automatic bus_access(input reg_addr_t addr, input logic write,
                             input reg_data_t wdata, output reg_data_t rdata);
      @(negedge clk_dot4x);
      while (clk_phi_o) @(negedge clk_dot4x);
      @(posedge clk_dot4x);
      #1;
      adi_i = addr;
      dbi_i = wdata;
      rw_i  = !write;
      ce_i  = 1'b0;
      @(negedge clk_dot4x);
      // transceiver turns only for reads
      check_bit("ls245_data_dir_o", ls245_data_dir_o, write);
      while (!clk_phi_o) @(negedge clk_dot4x);
      while (clk_phi_o) @(negedge clk_dot4x);
      rdata = dbo_o;
      @(posedge clk_dot4x);
      #1;
      ce_i = 1'b1;
      rw_i = 1'b1;
      @(negedge clk_dot4x);
      check_bit("ls245_data_dir_o", ls245_data_dir_o, 1'b1);
   endtask

   task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
      reg_data_t unused_rd;
      bus_access(addr, 1'b1, data, unused_rd);
   endtask

   task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
      bus_access(addr, 1'b0, 8'h00, data);
   endtask

   // phi is 16 high and 16 low with one pixel every 4 clocks
   task automatic phi_and_dot_timing();
      int        high_cnt;
      int        low_cnt;
      int        gap;
      raster_x_t x_prev;
      skip_to_phi_high();
      high_cnt = 0;
      while (clk_phi_o) begin
         high_cnt++;
         @(negedge clk_dot4x);
      end
      low_cnt = 0;
      while (!clk_phi_o) begin
         low_cnt++;
         @(negedge clk_dot4x);
      end
      check_count("clk_phi_o high clocks", high_cnt, 16);
      check_count("clk_phi_o low clocks", low_cnt, 16);
      x_prev = raster_x_o;
      while (raster_x_o == x_prev) @(negedge clk_dot4x);
      repeat (8) begin
         x_prev = raster_x_o;
         gap    = 0;
         while (raster_x_o == x_prev) begin
            @(negedge clk_dot4x);
            gap++;
         end
         check_count("clocks per raster_x step", gap, 4);
         check_x("raster_x_o", raster_x_o, x_prev + 10'd1);
      end
   endtask

   task automatic register_readback();
      reg_data_t rd;
      irq_bits_t en_pattern;
      d011_val = reg_data_t'($random(seed));
      write_reg(`VIC_REG_CTRL1, d011_val);
      read_reg(`VIC_REG_CTRL1, rd);
      // bit 7 shows line bit 8 which is still low on line 0
      check_data("$d011", rd, {1'b0, d011_val[6:0]});
      en_pattern = irq_bits_t'($random(seed));
      write_reg(`VIC_REG_IRQ_EN, {4'h0, en_pattern});
      read_reg(`VIC_REG_IRQ_EN, rd);
      check_data("$d01a enables", {4'h0, rd[3:0]}, {4'h0, en_pattern});
      read_reg(6'h20, rd);
      check_data("unmapped $d020", rd, 8'hff);
      read_reg(6'h00, rd);
      check_data("unmapped $d000", rd, 8'hff);
   endtask

   task automatic pal_x_peak();
      raster_x_t x_peak;
      apply_reset(CHIP_6569);
      x_peak = '0;
      @(negedge clk_dot4x);
      while (raster_line_o == 9'd0) begin
         if (raster_x_o > x_peak)
            x_peak = raster_x_o;
         @(negedge clk_dot4x);
      end
      check_x("raster_x_o peak on 6569", x_peak, `VIC_XMAX_6569);
      check_x("raster_x_o after wrap", raster_x_o, 10'd0);
      check_line("raster_line_o after wrap", raster_line_o, 9'd1);
   endtask

   // one full 6567R8 frame including line bit 8 in $d011
   task automatic ntsc_frame_wrap();
      reg_data_t rd;
      apply_reset(CHIP_6567R8);
      @(negedge clk_dot4x);
      while (raster_x_o != 10'd519) @(negedge clk_dot4x);
      while (raster_x_o == 10'd519) @(negedge clk_dot4x);
      check_x("raster_x_o after 519", raster_x_o, 10'd0);
      check_line("raster_line_o after x wrap", raster_line_o, 9'd1);
      write_reg(`VIC_REG_CTRL1, d011_val);
      wait_line(9'd258, 1'b0);
      read_reg(`VIC_REG_CTRL1, rd);
      check_data("$d011 on line 258", rd, {1'b1, d011_val[6:0]});
      wait_line(9'd262, 1'b0);
      while (raster_x_o != 10'd519) @(negedge clk_dot4x);
      while (raster_x_o == 10'd519) @(negedge clk_dot4x);
      check_x("raster_x_o at frame wrap", raster_x_o, 10'd0);
      check_line("raster_line_o at frame wrap", raster_line_o, 9'd0);
   endtask

   task automatic raster_irq_sequence();
      int           rnd;
      int           n;
      raster_line_t cmp_line;
      reg_data_t    rd;
      apply_reset(CHIP_6567R8);
      rnd      = $random(seed);
      cmp_line = raster_line_t'(2 + ((rnd & 32'h7fff_ffff) % 37));
      write_reg(`VIC_REG_RASTER, cmp_line[7:0]);
      // compare of 0 after reset already latched on line 0
      write_reg(`VIC_REG_IRQ, 8'h01);
      write_reg(`VIC_REG_IRQ_EN, 8'h01);
      wait_line(cmp_line, 1'b1);
      n = 0;
      while (!irq_o) begin
         @(negedge clk_dot4x);
         n++;
         if (n > 100)
            stop_with_error("irq_o did not rise on the compare line");
      end
      check_line("raster_line_o at irq", raster_line_o, cmp_line);
      write_reg(`VIC_REG_IRQ, 8'h01);
      check_bit("irq_o after ack", irq_o, 1'b0);
      // next line with the source masked
      write_reg(`VIC_REG_IRQ_EN, 8'h00);
      write_reg(`VIC_REG_RASTER, cmp_line[7:0] + 8'd1);
      wait_line(cmp_line + 9'd1, 1'b1);
      wait_line(cmp_line + 9'd2, 1'b1);
      read_reg(`VIC_REG_IRQ, rd);
      check_data("$d019 sources", {4'h0, rd[3:0]}, 8'h01);
      check_bit("irq_o while masked", irq_o, 1'b0);
   endtask

   task automatic bad_line_bus_steal();
      int   n;
      logic phi_prev;
      apply_reset(CHIP_6567R8);
      // den on, rsel on, yscroll 3
      write_reg(`VIC_REG_CTRL1, 8'h1b);
      wait_line(9'd50, 1'b0);
      while (raster_line_o == 9'd50) begin
         phi_prev = clk_phi_o;
         @(negedge clk_dot4x);
         if (raster_line_o == 9'd50) begin
            check_bit("ba_o on line 50", ba_o, 1'b1);
            check_bit("aec_o on line 50", aec_o, phi_prev);
            check_bit("ls245_addr_dir_o on line 50", ls245_addr_dir_o, phi_prev);
         end
      end
      n = 0;
      while (ba_o) begin
         @(negedge clk_dot4x);
         n++;
         if (n > 64)
            stop_with_error("ba_o did not go low on bad line 51");
      end
      check_line("raster_line_o at ba low", raster_line_o, 9'd51);
      // three cascade shifts before the stolen phi high
      repeat (4) skip_to_phi_high();
      while (clk_phi_o) begin
         check_bit("ba_o", ba_o, 1'b0);
         check_bit("aec_o", aec_o, 1'b0);
         check_bit("ls245_addr_dir_o", ls245_addr_dir_o, 1'b0);
         @(negedge clk_dot4x);
      end
   endtask

   initial begin
      seed        = 59766;
      error_count = 0;
      cycle_count = 0;
      rst         = 1'b1;
      chip_i      = CHIP_6567R8;
      adi_i       = '0;
      dbi_i       = '0;
      ce_i        = 1'b1;
      rw_i        = 1'b1;
      d011_val    = '0;
      apply_reset(CHIP_6567R8);
      phi_and_dot_timing();
      register_readback();
      pal_x_peak();
      ntsc_frame_wrap();
      raster_irq_sequence();
      bad_line_bus_steal();
      if (error_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vicii.sv ====
`default_nettype none

module vicii (
   input  wire logic                         clk_dot4x,
   input  wire logic                         rst,
   input  wire vic_timing_pkg::chip_e        chip_i,
   input  wire vic_bus_pkg::reg_addr_t       adi_i,
   input  wire vic_bus_pkg::reg_data_t       dbi_i,
   input  wire logic                         ce_i,
   input  wire logic                         rw_i,
   output wire logic                         clk_phi_o,
   output wire vic_timing_pkg::raster_x_t    raster_x_o,
   output wire vic_timing_pkg::raster_line_t raster_line_o,
   output wire vic_bus_pkg::reg_data_t       dbo_o,
   output wire logic                         irq_o,
   output wire logic                         ba_o,
   output wire logic                         aec_o,
   output wire logic                         ls245_data_dir_o,
   output wire logic                         ls245_addr_dir_o
);

   import vic_timing_pkg::*;

   // phase generator fan-out
   logic          dot_rise;
   phase_strobe_t phase_start;

   // raster to registers and arbiter
   raster_line_t raster_line_d;
   raster_line_t irq_compare;
   logic         irq_match;

   // $d011 fields steering bad lines
   logic [2:0] yscroll;
   logic       den;

   vic_phase_gen u_phase_gen (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .clk_phi_o     (clk_phi_o),
      .dot_rise_o    (dot_rise),
      .phase_start_o (phase_start)
   );

   vic_raster u_raster (
      .clk_dot4x       (clk_dot4x),
      .rst             (rst),
      .chip_i          (chip_i),
      .dot_rise_i      (dot_rise),
      .clk_phi_i       (clk_phi_o),
      .phase_start_i   (phase_start),
      .irq_compare_i   (irq_compare),
      .raster_x_o      (raster_x_o),
      .raster_line_o   (raster_line_o),
      .raster_line_d_o (raster_line_d),
      .irq_match_o     (irq_match)
   );

   // cpu sees the delayed line, as the compare does
   vic_registers u_registers (
      .clk_dot4x       (clk_dot4x),
      .rst             (rst),
      .clk_phi_i       (clk_phi_o),
      .phase_start_i   (phase_start),
      .ce_i            (ce_i),
      .rw_i            (rw_i),
      .adi_i           (adi_i),
      .dbi_i           (dbi_i),
      .raster_line_d_i (raster_line_d),
      .irq_match_i     (irq_match),
      .dbo_o           (dbo_o),
      .irq_o           (irq_o),
      .yscroll_o       (yscroll),
      .den_o           (den),
      .irq_compare_o   (irq_compare)
   );

   vic_bus_arbiter u_bus_arbiter (
      .clk_dot4x        (clk_dot4x),
      .rst              (rst),
      .chip_i           (chip_i),
      .clk_phi_i        (clk_phi_o),
      .phase_start_i    (phase_start),
      .raster_x_i       (raster_x_o),
      .raster_line_i    (raster_line_o),
      .raster_line_d_i  (raster_line_d),
      .yscroll_i        (yscroll),
      .den_i            (den),
      .ce_i             (ce_i),
      .rw_i             (rw_i),
      .ba_o             (ba_o),
      .aec_o            (aec_o),
      .ls245_data_dir_o (ls245_data_dir_o),
      .ls245_addr_dir_o (ls245_addr_dir_o)
   );

endmodule

`default_nettype wire

// ==== vic_bus_arbiter.sv ====
`default_nettype none

`include "vic_params.svh"

module vic_bus_arbiter (
   input  wire logic                          clk_dot4x,
   input  wire logic                          rst,
   input  wire vic_timing_pkg::chip_e         chip_i,
   input  wire logic                          clk_phi_i,
   input  wire vic_timing_pkg::phase_strobe_t phase_start_i,
   input  wire vic_timing_pkg::raster_x_t     raster_x_i,
   input  wire vic_timing_pkg::raster_line_t  raster_line_i,
   input  wire vic_timing_pkg::raster_line_t  raster_line_d_i,
   input  wire logic [2:0]                    yscroll_i,
   input  wire logic                          den_i,
   input  wire logic                          ce_i,
   input  wire logic                          rw_i,
   output logic                               ba_o,
   output logic                               aec_o,
   output logic                               ls245_data_dir_o,
   output logic                               ls245_addr_dir_o
);

   import vic_timing_pkg::*;

   raster_x_t  chars_ba_start;
   cycle_num_t cycle_num;
   logic       allow_bad_lines;
   logic       allow_next;
   logic       badline;
   logic       in_char_window;
   // BA history, one stage per phi high
   logic       ba1;
   logic       ba2;
   logic       ba3;

   // ntsc chips drop BA a cycle earlier than pal
   always_comb begin
      case (chip_i)
         CHIP_6567R8, CHIP_6567R56A: chars_ba_start = `VIC_CHARS_BA_START_R8;
         default:                    chars_ba_start = `VIC_CHARS_BA_START_6569;
      endcase
   end

   assign cycle_num = raster_x_i[9:3];

   // window wraps across x=0, no repeats in this range
   assign in_char_window = (raster_x_i >= chars_ba_start) ||
                           (raster_x_i < `VIC_CHARS_BA_END);

   // den counts anywhere on line 48, including its first cycle
   // delayed line catches den set in the last cycle of 48
   always_comb begin
      allow_next = allow_bad_lines;
      if (den_i && ((raster_line_i == `VIC_FIRST_DMA_LINE && cycle_num == 7'd0) ||
                    raster_line_d_i == `VIC_FIRST_DMA_LINE))
         allow_next = 1'b1;
      if (raster_line_i == `VIC_LAST_DMA_LINE)
         allow_next = 1'b0;
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
         badline         <= 1'b0;
      end else if (!clk_phi_i && phase_start_i[`VIC_LINE_CHECK]) begin
         allow_bad_lines <= allow_next;
         badline <= (raster_line_i[2:0] == yscroll_i) && allow_next &&
                    (raster_line_i >= `VIC_FIRST_DMA_LINE) &&
                    (raster_line_i < `VIC_LAST_DMA_LINE);
      end
   end

   // low requests the bus for c-access
   assign ba_o = !(badline && in_char_window);

   // three phi high halves must pass before aec may stay low
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1 <= 1'b1;
         ba2 <= 1'b1;
         ba3 <= 1'b1;
      end else if (clk_phi_i && phase_start_i[`VIC_BA_SAMPLE]) begin
         ba1 <= ba_o;
         ba2 <= ba1 | ba_o;
         ba3 <= ba2 | ba_o;
      end
   end

   // aec tracks phi, held low in phi high once the cpu had its 3 cycles
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         aec_o <= 1'b0;
      else
         aec_o <= ba_o ? clk_phi_i : (ba3 & clk_phi_i);
   end

   // we drive the data bus only while the cpu reads us
   assign ls245_data_dir_o = !(rw_i && !ce_i);
   // aec low means we own the address bus
   assign ls245_addr_dir_o = aec_o;

   a_aec_stolen: assert property (@(posedge clk_dot4x) disable iff (rst)
      (clk_phi_i && !ba_o && !ba3) |=> !aec_o)
      else $error("aec_o high in phi high after BA cascade ran out");

endmodule

`default_nettype wire

// ==== vic_registers.sv ====
`default_nettype none

`include "vic_params.svh"

module vic_registers (
   input  wire logic                          clk_dot4x,
   input  wire logic                          rst,
   input  wire logic                          clk_phi_i,
   input  wire vic_timing_pkg::phase_strobe_t phase_start_i,
   input  wire logic                          ce_i,
   input  wire logic                          rw_i,
   input  wire vic_bus_pkg::reg_addr_t        adi_i,
   input  wire vic_bus_pkg::reg_data_t        dbi_i,
   input  wire vic_timing_pkg::raster_line_t  raster_line_d_i,
   input  wire logic                          irq_match_i,
   output vic_bus_pkg::reg_data_t             dbo_o,
   output logic                               irq_o,
   output logic [2:0]                         yscroll_o,
   output logic                               den_o,
   output vic_timing_pkg::raster_line_t       irq_compare_o
);

   import vic_bus_pkg::*;

   // remaining $d011 fields, only visible on read
   logic rsel;
   logic bmm;
   logic ecm;

   // raster interrupt latch and its once-per-match guard
   logic irst;
   logic raster_trig;

   irq_bits_t irq_latch;
   irq_bits_t irq_en;
   logic      cpu_cycle;
   logic      cpu_write;
   logic      cpu_read;
   reg_data_t rd_data;

   // cpu owns the bus in phi high, data valid at DAV
   assign cpu_cycle = !ce_i && clk_phi_i && phase_start_i[`VIC_DATA_DAV];
   assign cpu_write = cpu_cycle && !rw_i;
   assign cpu_read  = cpu_cycle && rw_i;

   // only the raster source exists, the rest stay 0
   always_comb begin
      irq_latch = '0;
      irq_latch[IRQ_RASTER] = irst;
   end

   // read mux, bit 7 of $d011 is the line's bit 8
   always_comb begin
      case (adi_i)
         `VIC_REG_CTRL1:  rd_data = {raster_line_d_i[8], ecm, bmm, den_o, rsel, yscroll_o};
         `VIC_REG_RASTER: rd_data = raster_line_d_i[7:0];
         `VIC_REG_IRQ:    rd_data = {|(irq_latch & irq_en), 3'b111, irq_latch};
         `VIC_REG_IRQ_EN: rd_data = {4'hf, irq_en};
         default:         rd_data = 8'hff;
      endcase
   end

   // register writes
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         {irq_compare_o[8], ecm, bmm, den_o, rsel, yscroll_o} <= '0;
         irq_compare_o[7:0] <= '0;
         irq_en             <= '0;
      end else if (cpu_write) begin
         case (adi_i)
            `VIC_REG_CTRL1:  {irq_compare_o[8], ecm, bmm, den_o, rsel, yscroll_o} <= dbi_i;
            `VIC_REG_RASTER: irq_compare_o[7:0] <= dbi_i;
            `VIC_REG_IRQ_EN: irq_en <= dbi_i[3:0];
            default: ;
         endcase
      end
   end

   // read data holds until the next cpu read
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         dbo_o <= 8'hff;
      else if (cpu_read)
         dbo_o <= rd_data;
   end

   // raster irq, sets once per match in phi low
   // guard drops again when the match goes away
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst        <= 1'b0;
         raster_trig <= 1'b0;
         irq_o       <= 1'b0;
      end else begin
         if (!irq_match_i) begin
            raster_trig <= 1'b0;
         end else if (!clk_phi_i && phase_start_i[`VIC_IRQ_CHECK] && !raster_trig) begin
            raster_trig <= 1'b1;
            irst        <= 1'b1;
         end
         // writing 1 acknowledges
         if (cpu_write && adi_i == `VIC_REG_IRQ && dbi_i[IRQ_RASTER])
            irst <= 1'b0;
         irq_o <= |(irq_latch & irq_en);
      end
   end

   // a disabled source must not reach the cpu on the next clock
   a_irq_gated: assert property (@(posedge clk_dot4x) disable iff (rst)
      !irq_en[IRQ_RASTER] |=> !irq_o)
      else $error("irq_o high with raster enable low");

endmodule

`default_nettype wire

// ==== vic_raster.sv ====
`default_nettype none

`include "vic_params.svh"

module vic_raster (
   input  wire logic                          clk_dot4x,
   input  wire logic                          rst,
   input  wire vic_timing_pkg::chip_e         chip_i,
   input  wire logic                          dot_rise_i,
   input  wire logic                          clk_phi_i,
   input  wire vic_timing_pkg::phase_strobe_t phase_start_i,
   input  wire vic_timing_pkg::raster_line_t  irq_compare_i,
   output vic_timing_pkg::raster_x_t          raster_x_o,
   output vic_timing_pkg::raster_line_t       raster_line_o,
   output vic_timing_pkg::raster_line_t       raster_line_d_o,
   output logic                               irq_match_o
);

   import vic_timing_pkg::*;

   // last pixel of a line for the selected chip
   raster_x_t x_max;
   // last line of a frame, table width is 10 bits
   logic [9:0] y_max;
   logic       x_wrap;

   // chip limit table
   always_comb begin
      case (chip_i)
         CHIP_6567R8: begin
            x_max = `VIC_XMAX_R8;
            y_max = `VIC_YMAX_R8;
         end
         CHIP_6567R56A: begin
            x_max = `VIC_XMAX_R56A;
            y_max = `VIC_YMAX_R56A;
         end
         // 6569 and the unused code share pal limits
         default: begin
            x_max = `VIC_XMAX_6569;
            y_max = `VIC_YMAX_6569;
         end
      endcase
   end

   // >= so a counter past the limit still recovers
   assign x_wrap = (raster_x_o >= x_max);

   // pixel counter steps on each dot, line counter on x wrap
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x_o    <= '0;
         raster_line_o <= '0;
      end else if (dot_rise_i) begin
         if (x_wrap) begin
            raster_x_o <= '0;
            if ({1'b0, raster_line_o} >= y_max)
               raster_line_o <= '0;
            else
               raster_line_o <= raster_line_o + 9'd1;
         end else begin
            raster_x_o <= raster_x_o + 10'd1;
         end
      end
   end

   // line as seen by the compare logic and the cpu
   // only moves at the start of a phi low half
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         raster_line_d_o <= '0;
      else if (!clk_phi_i && phase_start_i[0])
         raster_line_d_o <= raster_line_o;
   end

   // level, high for as long as the delayed line matches
   assign irq_match_o = (raster_line_d_o == irq_compare_i);

   a_x_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
      raster_x_o <= x_max)
      else $error("raster_x beyond chip maximum");

endmodule

`default_nettype wire

// ==== vic_phase_gen.sv ====
`default_nettype none

`include "vic_params.svh"

module vic_phase_gen (
   input  wire logic                     clk_dot4x,
   input  wire logic                     rst,
   output logic                          clk_phi_o,
   output logic                          dot_rise_o,
   output vic_timing_pkg::phase_strobe_t phase_start_o
);

   import vic_timing_pkg::*;

   // one full phi period, bit 0 is the phi level
   logic [2*`VIC_PHI_HALF-1:0] phi_ring;
   // single dot pulse every fourth clock
   logic [3:0] dot_ring;
   // current position inside a phi half
   phase_strobe_t phase_ring;

   // start with phi low, already a quarter into the low half
   // all three rings simply rotate afterwards
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_ring   <= 32'h000f_fff0;
         dot_ring   <= 4'b1000;
         phase_ring <= 16'h0008;
      end else begin
         phi_ring   <= {phi_ring[2*`VIC_PHI_HALF-2:0], phi_ring[2*`VIC_PHI_HALF-1]};
         dot_ring   <= {dot_ring[2:0], dot_ring[3]};
         phase_ring <= {phase_ring[14:0], phase_ring[15]};
      end
   end

   assign clk_phi_o     = phi_ring[0];
   assign dot_rise_o    = dot_ring[0];
   assign phase_start_o = phase_ring;

   // the phase ring must never lose or gain a token
   a_phase_onehot: assert property (@(posedge clk_dot4x) disable iff (rst)
      $onehot(phase_ring))
      else $error("phase ring is not one-hot");

   // phi and the phase ring must stay aligned: an edge exactly after bit 15
   a_phi_aligned: assert property (@(posedge clk_dot4x) disable iff (rst)
      $changed(clk_phi_o) == $past(phase_ring[15]))
      else $error("clk_phi edge out of step with phase ring");

endmodule

`default_nettype wire

// ==== vic_bus_pkg.sv ====
`default_nettype none

package vic_bus_pkg;

   // register select from the cpu address bus
   typedef logic [5:0] reg_addr_t;

   // cpu data bus
   typedef logic [7:0] reg_data_t;

   // interrupt sources in $d019 / $d01a order:
   // light pen, sprite-sprite, sprite-background, raster
   typedef logic [3:0] irq_bits_t;

   // bit position of the raster source, the only live one
   localparam int IRQ_RASTER = 0;

endpackage

`default_nettype wire

// ==== vic_timing_pkg.sv ====
`default_nettype none

package vic_timing_pkg;

   // chip variant, selects raster limits and BA window
   // unused code behaves like a 6569
   typedef enum logic [1:0] {
      CHIP_6567R8   = 2'd0,
      CHIP_6567R56A = 2'd1,
      CHIP_6569     = 2'd2,
      CHIP_UNUSED   = 2'd3
   } chip_e;

   // pixel position within a raster line
   typedef logic [9:0] raster_x_t;

   // raster line number
   typedef logic [8:0] raster_line_t;

   // cpu cycle within the line, raster_x / 8
   typedef logic [6:0] cycle_num_t;

   // one-hot position within a phi half period
   // bit 15 means phi flips on the next clock
   typedef logic [15:0] phase_strobe_t;

endpackage

`default_nettype wire

// ==== vic_params.svh ====
`ifndef VIC_PARAMS_SVH
`define VIC_PARAMS_SVH

// clk_dot4x cycles in one phi half period
`define VIC_PHI_HALF 16

// phase_start positions used for sampling and checks
`define VIC_DATA_DAV   13
`define VIC_BA_SAMPLE  15
`define VIC_IRQ_CHECK  8
`define VIC_LINE_CHECK 1

// lines bounding character dma (bad lines)
`define VIC_FIRST_DMA_LINE 9'd48
`define VIC_LAST_DMA_LINE  9'd248

// cpu visible register addresses
`define VIC_REG_CTRL1  6'h11
`define VIC_REG_RASTER 6'h12
`define VIC_REG_IRQ    6'h19
`define VIC_REG_IRQ_EN 6'h1a

// raster limits per chip, last pixel and last line
`define VIC_XMAX_R8   10'd519
`define VIC_XMAX_R56A 10'd511
`define VIC_XMAX_6569 10'd503
`define VIC_YMAX_R8   10'd262
`define VIC_YMAX_R56A 10'd261
`define VIC_YMAX_6569 10'd311

// x positions where BA drops and rises for c-access
`define VIC_CHARS_BA_START_R8   10'h1f4
`define VIC_CHARS_BA_START_6569 10'h1ec
`define VIC_CHARS_BA_END        10'h14c

`endif
